// File: logic/corePkg.sv
package corePkg;

  localparam int WordBits = 16;
  localparam int AddrBits = 8;

  typedef logic [WordBits-1:0] word_t;
  typedef logic [AddrBits-1:0] addr_t;

  // Opcode, rd, rs1, rs2, immediate
  typedef logic [15:0] instr_t;
  typedef logic [1:0] regIdx_t;

  typedef enum logic [3:0] {
    HALT  = 4'd0,
    LOADI = 4'd1,
    LOAD  = 4'd2,
    STORE = 4'd3,
    ADD   = 4'd4,
    BNZ   = 4'd5
  } opcode_e;

  typedef enum logic [2:0] {
    FETCH,
    FETCH_WAIT,
    EXECUTE,
    DATA_WAIT,
    HALTED
  } pipeState_e;

  typedef enum logic [2:0] {
    EVT_INSTRET,
    EVT_ICACHE_ACCESS,
    EVT_ICACHE_MISS,
    EVT_DCACHE_ACCESS,
    EVT_DCACHE_MISS
  } hpmEvt_e;

  localparam int HpmEventNum = 5;
  typedef logic [2:0] hpmSel_t;
  typedef logic [15:0] count_t;

  localparam int CacheIndexBits = 3;
  localparam int CacheLines = 1 << CacheIndexBits;
  typedef logic [CacheIndexBits-1:0] cacheIndex_t;
  typedef logic [AddrBits-CacheIndexBits-1:0] cacheTag_t;

endpackage

// File: logic/memPortIf.sv
`timescale 1ns/1ps

// One-cycle request strobe, answered later by a one-cycle ack
interface memPortIf;

  logic           req;
  logic           we;
  corePkg::addr_t addr;
  corePkg::word_t wdata;
  logic           ack;
  corePkg::word_t rdata;

  modport requester (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport responder (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

// File: logic/hpmCounters.sv
`timescale 1ns/1ps

module hpmCounters (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [corePkg::HpmEventNum-1:0] hpmEvent_i,
  input  corePkg::hpmSel_t                hpmSel_i,
  output corePkg::count_t                 hpmValue_o
);

  corePkg::count_t counters [corePkg::HpmEventNum];

  // Saturate at all ones
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < corePkg::HpmEventNum; i++) begin
        counters[i] <= '0;
      end
    end else begin
      for (int i = 0; i < corePkg::HpmEventNum; i++) begin
        if (hpmEvent_i[i] && counters[i] != '1) begin
          counters[i] <= counters[i] + 1'b1;
        end
      end
    end
  end

  // Out-of-range select reads zero
  always_comb begin
    hpmValue_o = '0;
    for (int i = 0; i < corePkg::HpmEventNum; i++) begin
      if (hpmSel_i == corePkg::hpmSel_t'(i)) begin
        hpmValue_o = counters[i];
      end
    end
  end

endmodule

// File: logic/corePipeline.sv
`timescale 1ns/1ps

module corePipeline (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [corePkg::HpmEventNum-1:0] hpmEvent_i,
  input  corePkg::hpmSel_t                hpmSel_i,
  output logic                            halted_o,
  output corePkg::count_t                 hpmValue_o,
  output logic                            instret_o,
  memPortIf.requester                     icachePort,
  memPortIf.requester                     dcachePort
);

  corePkg::pipeState_e state;
  corePkg::addr_t      pc;
  corePkg::instr_t     instr;
  corePkg::word_t      regFile [4];

  corePkg::opcode_e opcode;
  corePkg::regIdx_t rdIdx;
  corePkg::regIdx_t rs1Idx;
  corePkg::regIdx_t rs2Idx;
  corePkg::addr_t   imm;
  logic             isMemOp;

  // Decode fields of the latched instruction
  assign opcode  = corePkg::opcode_e'(instr[15:12]);
  assign rdIdx   = instr[11:10];
  assign rs1Idx  = instr[9:8];
  assign rs2Idx  = instr[7:6];
  assign imm     = instr[7:0];
  assign isMemOp = (opcode == corePkg::LOAD) || (opcode == corePkg::STORE);

  assign icachePort.req   = (state == corePkg::FETCH);
  assign icachePort.we    = 1'b0;
  assign icachePort.addr  = pc;
  assign icachePort.wdata = '0;

  // Held stable through DATA_WAIT since instr and regFile do not change there
  assign dcachePort.req   = (state == corePkg::EXECUTE) && isMemOp;
  assign dcachePort.we    = (opcode == corePkg::STORE);
  assign dcachePort.addr  = imm;
  assign dcachePort.wdata = regFile[rdIdx];

  assign halted_o = (state == corePkg::HALTED);

  always_comb begin
    instret_o = 1'b0;
    if (state == corePkg::EXECUTE) begin
      instret_o = opcode inside {corePkg::LOADI, corePkg::ADD, corePkg::BNZ};
    end else if (state == corePkg::DATA_WAIT) begin
      instret_o = dcachePort.ack;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state <= corePkg::FETCH;
      pc    <= '0;
      for (int i = 0; i < 4; i++) begin
        regFile[i] <= '0;
      end
    end else begin
      unique case (state)
        corePkg::FETCH: state <= corePkg::FETCH_WAIT;
        corePkg::FETCH_WAIT: begin
          if (icachePort.ack) begin
            state <= corePkg::EXECUTE;
          end
        end
        corePkg::EXECUTE: begin
          case (opcode)
            corePkg::LOADI: begin
              regFile[rdIdx] <= corePkg::word_t'(imm);
              pc             <= pc + 8'd1;
              state          <= corePkg::FETCH;
            end
            corePkg::ADD: begin
              // Wraps modulo 2^16
              regFile[rdIdx] <= regFile[rs1Idx] + regFile[rs2Idx];
              pc             <= pc + 8'd1;
              state          <= corePkg::FETCH;
            end
            corePkg::BNZ: begin
              pc    <= (regFile[rdIdx] != '0) ? imm : pc + 8'd1;
              state <= corePkg::FETCH;
            end
            corePkg::LOAD, corePkg::STORE: state <= corePkg::DATA_WAIT;
            // HALT and unknown opcodes
            default: state <= corePkg::HALTED;
          endcase
        end
        corePkg::DATA_WAIT: begin
          if (dcachePort.ack) begin
            if (opcode == corePkg::LOAD) begin
              regFile[rdIdx] <= dcachePort.rdata;
            end
            pc    <= pc + 8'd1;
            state <= corePkg::FETCH;
          end
        end
        default: state <= corePkg::HALTED;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == corePkg::FETCH_WAIT && icachePort.ack) begin
      instr <= icachePort.rdata;
    end
  end

  hpmCounters counters (
    .clk_i,
    .reset_i,
    .hpmEvent_i,
    .hpmSel_i,
    .hpmValue_o
  );

endmodule

// File: logic/instrCache.sv
`timescale 1ns/1ps

module instrCache (
  input  logic        clk_i,
  input  logic        reset_i,
  output logic        hpmAccess_o,
  output logic        hpmMiss_o,
  memPortIf.responder cachePort,
  memPortIf.requester busPort
);

  logic [corePkg::CacheLines-1:0] lineValid;
  corePkg::cacheTag_t             lineTag  [corePkg::CacheLines];
  corePkg::word_t                 lineData [corePkg::CacheLines];

  corePkg::cacheIndex_t index;
  corePkg::cacheTag_t   tag;
  logic                 hit;
  logic                 ackQ;
  corePkg::word_t       rdataQ;
  logic                 busReqQ;

  assign index = cachePort.addr[corePkg::CacheIndexBits-1:0];
  assign tag   = cachePort.addr[corePkg::AddrBits-1:corePkg::CacheIndexBits];
  assign hit   = lineValid[index] && (lineTag[index] == tag);

  assign cachePort.ack   = ackQ;
  assign cachePort.rdata = rdataQ;

  // Requester address stays stable until our ack, so reuse it for the refill
  assign busPort.req   = busReqQ;
  assign busPort.we    = 1'b0;
  assign busPort.addr  = cachePort.addr;
  assign busPort.wdata = '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lineValid   <= '0;
      ackQ        <= 1'b0;
      busReqQ     <= 1'b0;
      hpmAccess_o <= 1'b0;
      hpmMiss_o   <= 1'b0;
    end else begin
      ackQ        <= 1'b0;
      busReqQ     <= 1'b0;
      hpmAccess_o <= cachePort.req;
      hpmMiss_o   <= cachePort.req && !hit;
      if (cachePort.req) begin
        if (hit) begin
          ackQ <= 1'b1;
        end else begin
          busReqQ <= 1'b1;
        end
      end
      if (busPort.ack) begin
        lineValid[index] <= 1'b1;
        ackQ             <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cachePort.req && hit) begin
      rdataQ <= lineData[index];
    end
    if (busPort.ack) begin
      lineData[index] <= busPort.rdata;
      lineTag[index]  <= tag;
      rdataQ          <= busPort.rdata;
    end
  end

endmodule

// File: logic/dataCache.sv
`timescale 1ns/1ps

module dataCache (
  input  logic        clk_i,
  input  logic        reset_i,
  output logic        hpmAccess_o,
  output logic        hpmMiss_o,
  memPortIf.responder cachePort,
  memPortIf.requester busPort
);

  logic [corePkg::CacheLines-1:0] lineValid;
  corePkg::cacheTag_t             lineTag  [corePkg::CacheLines];
  corePkg::word_t                 lineData [corePkg::CacheLines];

  corePkg::cacheIndex_t index;
  corePkg::cacheTag_t   tag;
  logic                 hit;
  logic                 loadHit;
  logic                 storeHit;
  logic                 ackQ;
  corePkg::word_t       rdataQ;
  logic                 busReqQ;

  assign index    = cachePort.addr[corePkg::CacheIndexBits-1:0];
  assign tag      = cachePort.addr[corePkg::AddrBits-1:corePkg::CacheIndexBits];
  assign hit      = lineValid[index] && (lineTag[index] == tag);
  assign loadHit  = cachePort.req && !cachePort.we && hit;
  assign storeHit = cachePort.req && cachePort.we && hit;

  assign cachePort.ack   = ackQ;
  assign cachePort.rdata = rdataQ;

  // Stores always go through, loads only on a miss
  assign busPort.req   = busReqQ;
  assign busPort.we    = cachePort.we;
  assign busPort.addr  = cachePort.addr;
  assign busPort.wdata = cachePort.wdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lineValid   <= '0;
      ackQ        <= 1'b0;
      busReqQ     <= 1'b0;
      hpmAccess_o <= 1'b0;
      hpmMiss_o   <= 1'b0;
    end else begin
      ackQ        <= 1'b0;
      busReqQ     <= 1'b0;
      hpmAccess_o <= cachePort.req;
      // A store is never counted as a miss
      hpmMiss_o   <= cachePort.req && !cachePort.we && !hit;
      if (cachePort.req) begin
        if (loadHit) begin
          ackQ <= 1'b1;
        end else begin
          busReqQ <= 1'b1;
        end
      end
      if (busPort.ack) begin
        if (!cachePort.we) begin
          lineValid[index] <= 1'b1;
        end
        ackQ <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (storeHit) begin
      lineData[index] <= cachePort.wdata;
    end
    if (loadHit) begin
      rdataQ <= lineData[index];
    end
    if (busPort.ack) begin
      rdataQ <= busPort.rdata;
      // No write-allocate
      if (!cachePort.we) begin
        lineData[index] <= busPort.rdata;
        lineTag[index]  <= tag;
      end
    end
  end

endmodule

// File: logic/busArbiter.sv
`timescale 1ns/1ps

module busArbiter (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           memAck_i,
  input  corePkg::word_t memRdata_i,
  output logic           memReq_o,
  output logic           memWe_o,
  output corePkg::addr_t memAddr_o,
  output corePkg::word_t memWdata_o,
  memPortIf.responder    icacheBus,
  memPortIf.responder    dcacheBus
);

  logic           busy;
  logic           grantDcache;
  logic           icacheAck;
  logic           dcacheAck;
  corePkg::word_t rdataQ;

  assign icacheBus.ack   = icacheAck;
  assign icacheBus.rdata = rdataQ;
  assign dcacheBus.ack   = dcacheAck;
  assign dcacheBus.rdata = rdataQ;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy      <= 1'b0;
      memReq_o  <= 1'b0;
      icacheAck <= 1'b0;
      dcacheAck <= 1'b0;
    end else begin
      memReq_o  <= 1'b0;
      icacheAck <= 1'b0;
      dcacheAck <= 1'b0;
      if (!busy && (dcacheBus.req || icacheBus.req)) begin
        busy     <= 1'b1;
        memReq_o <= 1'b1;
      end
      // Route the ack to whoever holds the grant
      if (busy && memAck_i) begin
        busy      <= 1'b0;
        dcacheAck <= grantDcache;
        icacheAck <= !grantDcache;
      end
    end
  end

  // Data cache wins a tie
  always_ff @(posedge clk_i) begin
    if (!busy && dcacheBus.req) begin
      grantDcache <= 1'b1;
      memWe_o     <= dcacheBus.we;
      memAddr_o   <= dcacheBus.addr;
      memWdata_o  <= dcacheBus.wdata;
    end else if (!busy && icacheBus.req) begin
      grantDcache <= 1'b0;
      memWe_o     <= icacheBus.we;
      memAddr_o   <= icacheBus.addr;
      memWdata_o  <= icacheBus.wdata;
    end
    if (memAck_i) begin
      rdataQ <= memRdata_i;
    end
  end

endmodule

// File: logic/coreTop.sv
`timescale 1ns/1ps

module coreTop (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             memAck_i,
  input  corePkg::word_t   memRdata_i,
  input  corePkg::hpmSel_t hpmSel_i,
  output logic             memReq_o,
  output logic             memWe_o,
  output corePkg::addr_t   memAddr_o,
  output corePkg::word_t   memWdata_o,
  output logic             halted_o,
  output corePkg::count_t  hpmValue_o
);

  memPortIf icachePort ();
  memPortIf dcachePort ();
  memPortIf icacheBus ();
  memPortIf dcacheBus ();

  logic [corePkg::HpmEventNum-1:0] hpmEvent;
  logic instret;
  logic hpmIcacheAccess;
  logic hpmIcacheMiss;
  logic hpmDcacheAccess;
  logic hpmDcacheMiss;

  // Fold cache and retire pulses into one event vector
  always_comb begin
    hpmEvent = '0;
    hpmEvent[corePkg::EVT_INSTRET]       = instret;
    hpmEvent[corePkg::EVT_ICACHE_ACCESS] = hpmIcacheAccess;
    hpmEvent[corePkg::EVT_ICACHE_MISS]   = hpmIcacheMiss;
    hpmEvent[corePkg::EVT_DCACHE_ACCESS] = hpmDcacheAccess;
    hpmEvent[corePkg::EVT_DCACHE_MISS]   = hpmDcacheMiss;
  end

  corePipeline pipeline (
    .clk_i,
    .reset_i,
    .hpmEvent_i (hpmEvent),
    .hpmSel_i,
    .halted_o,
    .hpmValue_o,
    .instret_o  (instret),
    .icachePort (icachePort),
    .dcachePort (dcachePort)
  );

  instrCache icacheInst (
    .clk_i,
    .reset_i,
    .hpmAccess_o (hpmIcacheAccess),
    .hpmMiss_o   (hpmIcacheMiss),
    .cachePort   (icachePort),
    .busPort     (icacheBus)
  );

  dataCache dcacheInst (
    .clk_i,
    .reset_i,
    .hpmAccess_o (hpmDcacheAccess),
    .hpmMiss_o   (hpmDcacheMiss),
    .cachePort   (dcachePort),
    .busPort     (dcacheBus)
  );

  busArbiter arbiter (
    .clk_i,
    .reset_i,
    .memAck_i,
    .memRdata_i,
    .memReq_o,
    .memWe_o,
    .memAddr_o,
    .memWdata_o,
    .icacheBus (icacheBus),
    .dcacheBus (dcacheBus)
  );

endmodule

// File: tests/coreTopTb.sv
`timescale 1ns/1ps

module coreTopTb;

  localparam int ResetCycles    = 10;
  localparam int HaltHoldCycles = 20;
  localparam int HaltWaitLimit  = 400;
  localparam int MaxLatency     = 4;
  // Instructions executed over all programs, and the number of program runs
  localparam int ExecInstrs     = 41;
  localparam int ProgramRuns    = 8;
  localparam int RunOverhead    = ResetCycles + HaltHoldCycles + 10;
  localparam int TimeoutCycles  =
    ExecInstrs * (2 + 2 * MaxLatency) * 2 + ProgramRuns * RunOverhead;

  logic             clk_i;
  logic             reset_i    = 1'b1;
  logic             memAck_i   = 1'b0;
  corePkg::word_t   memRdata_i = '0;
  corePkg::hpmSel_t hpmSel_i   = '0;
  logic             memReq_o;
  logic             memWe_o;
  corePkg::addr_t   memAddr_o;
  corePkg::word_t   memWdata_o;
  logic             halted_o;
  corePkg::count_t  hpmValue_o;

  corePkg::word_t mem [256];
  logic           pending;
  int             waitCycles;
  logic           reqWe;
  corePkg::addr_t reqAddr;
  corePkg::word_t reqWdata;
  int             writeCount;
  logic [31:0]    lfsrState = 32'h02a4_d05f;
  int             cycleCount = 0;
  int             checks = 0;
  int             errors = 0;

  coreTop dut (
    .clk_i,
    .reset_i,
    .memAck_i,
    .memRdata_i,
    .hpmSel_i,
    .memReq_o,
    .memWe_o,
    .memAddr_o,
    .memWdata_o,
    .halted_o,
    .hpmValue_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hA300_0000;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic int drawBits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsrState[0]);
      lfsrState = lfsrNext(lfsrState);
    end
    return v;
  endfunction

  // Memory model that acks each request after 1 to 4 cycles
  always @(posedge clk_i) begin
    memAck_i <= 1'b0;
    if (reset_i) begin
      pending = 1'b0;
      writeCount = 0;
    end else if (pending) begin
      if (waitCycles == 1) begin
        pending = 1'b0;
        memAck_i <= 1'b1;
        if (reqWe) begin
          mem[reqAddr] = reqWdata;
          writeCount++;
        end else begin
          memRdata_i <= mem[reqAddr];
        end
      end else begin
        waitCycles--;
      end
    end else if (memReq_o) begin
      pending = 1'b1;
      waitCycles = 1 + drawBits(2);
      reqWe = memWe_o;
      reqAddr = memAddr_o;
      reqWdata = memWdata_o;
    end
  end

  always @(posedge clk_i) begin
    cycleCount++;
    if (cycleCount > TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic checkWord(input string name, input corePkg::word_t actual,
                           input corePkg::word_t expected);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic checkCount(input string name, input corePkg::count_t actual,
                            input corePkg::count_t expected);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic checkFlag(input string name, input bit actual, input bit expected);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      errors++;
    end
  endtask

  function automatic corePkg::instr_t encodeImm(input corePkg::opcode_e op,
                                                input corePkg::regIdx_t rd,
                                                input corePkg::addr_t imm);
    return {op, rd, 2'b00, imm};
  endfunction

  function automatic corePkg::instr_t encodeAdd(input corePkg::regIdx_t rd,
                                                input corePkg::regIdx_t rs1,
                                                input corePkg::regIdx_t rs2);
    return {corePkg::ADD, rd, rs1, rs2, 6'b000000};
  endfunction

  // Background pattern that differs for every address
  task automatic clearMemory();
    for (int i = 0; i < 256; i++) begin
      mem[i] = {~8'(i), 8'(i)};
    end
  endtask

  task automatic resetDut();
    @(posedge clk_i);
    reset_i <= 1'b1;
    repeat (ResetCycles) @(posedge clk_i);
    reset_i <= 1'b0;
  endtask

  task automatic runProgram();
    int waited;
    resetDut();
    @(posedge clk_i);
    waited = 0;
    while (halted_o !== 1'b1 && waited < HaltWaitLimit) begin
      @(posedge clk_i);
      waited++;
    end
    if (halted_o !== 1'b1) begin
      $display("ERROR: program did not halt within %0d cycles", HaltWaitLimit);
      errors++;
    end
  endtask

  task automatic expectCounter(input string name, input corePkg::hpmEvt_e evt,
                               input corePkg::count_t expected);
    @(posedge clk_i);
    hpmSel_i <= corePkg::hpmSel_t'(evt);
    @(posedge clk_i);
    checkCount(name, hpmValue_o, expected);
  endtask

  // Instruction-level walk of the loaded program
  function automatic void walkProgram(output int fetched, output int retired,
                                      output int distinct);
    corePkg::word_t  regs [4];
    logic [255:0]    seen;
    corePkg::addr_t  pc;
    corePkg::instr_t ins;
    bit              running;
    regs = '{default: '0};
    seen = '0;
    pc = '0;
    fetched = 0;
    retired = 0;
    running = 1'b1;
    while (running && fetched < HaltWaitLimit) begin
      ins = mem[pc];
      seen[pc] = 1'b1;
      fetched++;
      retired++;
      pc = pc + 8'd1;
      case (ins[15:12])
        corePkg::LOADI: regs[ins[11:10]] = {8'h00, ins[7:0]};
        corePkg::LOAD:  regs[ins[11:10]] = mem[ins[7:0]];
        corePkg::STORE: ;
        corePkg::ADD:   regs[ins[11:10]] = regs[ins[9:8]] + regs[ins[7:6]];
        corePkg::BNZ: begin
          if (regs[ins[11:10]] != '0) begin
            pc = ins[7:0];
          end
        end
        default: begin
          retired--;
          running = 1'b0;
        end
      endcase
    end
    distinct = $countones(seen);
  endfunction

  task automatic testLoadiStore();
    clearMemory();
    mem[0] = encodeImm(corePkg::LOADI, 2'd0, 8'h12);
    mem[1] = encodeImm(corePkg::LOADI, 2'd1, 8'hAB);
    mem[2] = encodeImm(corePkg::STORE, 2'd0, 8'h40);
    mem[3] = encodeImm(corePkg::STORE, 2'd1, 8'h41);
    mem[4] = encodeImm(corePkg::HALT, 2'd0, 8'h00);
    runProgram();
    checkWord("mem[0x40]", mem[8'h40], 16'h0012);
    checkWord("mem[0x41]", mem[8'h41], 16'h00AB);
    checkCount("memory writes", corePkg::count_t'(writeCount), 16'd2);
  endtask

  task automatic testAdd(input corePkg::word_t a, input corePkg::word_t b,
                         input corePkg::word_t expected);
    clearMemory();
    mem[8'h50] = a;
    mem[8'h51] = b;
    mem[0] = encodeImm(corePkg::LOAD, 2'd0, 8'h50);
    mem[1] = encodeImm(corePkg::LOAD, 2'd1, 8'h51);
    mem[2] = encodeAdd(2'd2, 2'd0, 2'd1);
    mem[3] = encodeImm(corePkg::STORE, 2'd2, 8'h52);
    mem[4] = encodeImm(corePkg::HALT, 2'd0, 8'h00);
    runProgram();
    checkWord("mem[0x52]", mem[8'h52], expected);
  endtask

  task automatic testIcacheLoop();
    int fetched;
    int retired;
    int distinct;
    clearMemory();
    mem[8'h60] = 16'hFFFF;
    mem[0] = encodeImm(corePkg::LOADI, 2'd0, 8'd3);
    mem[1] = encodeImm(corePkg::LOAD, 2'd1, 8'h60);
    mem[2] = encodeAdd(2'd0, 2'd0, 2'd1);
    mem[3] = encodeImm(corePkg::BNZ, 2'd0, 8'd2);
    mem[4] = encodeImm(corePkg::HALT, 2'd0, 8'h00);
    walkProgram(fetched, retired, distinct);
    runProgram();
    expectCounter("icache accesses", corePkg::EVT_ICACHE_ACCESS, 16'(fetched));
    expectCounter("icache misses", corePkg::EVT_ICACHE_MISS, 16'(distinct));
    expectCounter("instret", corePkg::EVT_INSTRET, 16'(retired));
  endtask

  task automatic testStoreLoad();
    clearMemory();
    mem[8'h70] = 16'h1111;
    mem[0] = encodeImm(corePkg::LOAD, 2'd0, 8'h70);
    mem[1] = encodeImm(corePkg::LOADI, 2'd1, 8'h5A);
    mem[2] = encodeImm(corePkg::STORE, 2'd1, 8'h70);
    mem[3] = encodeImm(corePkg::LOAD, 2'd2, 8'h70);
    // Store miss that shows what the second load returned
    mem[4] = encodeImm(corePkg::STORE, 2'd2, 8'h71);
    mem[5] = encodeImm(corePkg::HALT, 2'd0, 8'h00);
    runProgram();
    checkWord("mem[0x70]", mem[8'h70], 16'h005A);
    checkWord("mem[0x71]", mem[8'h71], 16'h005A);
    expectCounter("dcache accesses", corePkg::EVT_DCACHE_ACCESS, 16'd4);
    expectCounter("dcache misses", corePkg::EVT_DCACHE_MISS, 16'd1);
  endtask

  task automatic testDcacheConflict();
    clearMemory();
    // Both at index 0 with tags 1 and 2
    mem[8'h08] = 16'h0100;
    mem[8'h10] = 16'h0023;
    mem[0] = encodeImm(corePkg::LOAD, 2'd0, 8'h08);
    mem[1] = encodeImm(corePkg::LOAD, 2'd1, 8'h10);
    mem[2] = encodeImm(corePkg::LOAD, 2'd2, 8'h08);
    mem[3] = encodeImm(corePkg::LOAD, 2'd3, 8'h10);
    mem[4] = encodeAdd(2'd0, 2'd2, 2'd3);
    mem[5] = encodeImm(corePkg::STORE, 2'd0, 8'h20);
    mem[6] = encodeImm(corePkg::HALT, 2'd0, 8'h00);
    runProgram();
    checkWord("mem[0x20]", mem[8'h20], 16'h0123);
    expectCounter("dcache misses", corePkg::EVT_DCACHE_MISS, 16'd4);
  endtask

  task automatic testHalt(input bit unknownOp);
    clearMemory();
    mem[0] = encodeImm(corePkg::LOADI, 2'd0, 8'd1);
    mem[1] = unknownOp ? 16'hF000 : encodeImm(corePkg::HALT, 2'd0, 8'h00);
    runProgram();
    repeat (HaltHoldCycles) begin
      @(posedge clk_i);
      checkFlag("halted_o", halted_o, 1'b1);
      checkFlag("memReq_o", memReq_o, 1'b0);
    end
    expectCounter("instret", corePkg::EVT_INSTRET, 16'd1);
  endtask

  initial begin
    testLoadiStore();
    testAdd(16'hFFFF, 16'h0002, 16'h0001);
    testAdd(16'h1234, 16'hBCDF, 16'hCF13);
    testIcacheLoop();
    testStoreLoad();
    testDcacheConflict();
    testHalt(1'b0);
    testHalt(1'b1);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: sources.f
logic/corePkg.sv
logic/memPortIf.sv
logic/hpmCounters.sv
logic/corePipeline.sv
logic/instrCache.sv
logic/dataCache.sv
logic/busArbiter.sv
logic/coreTop.sv
tests/coreTopTb.sv

// File: run.sh
#!/bin/sh
# Compile the core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module coreTopTb -f sources.f -o coreTopTbSim
./obj_dir/coreTopTbSim > sim.log 2>&1
cat sim.log
if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0
